//--- tb.f
+incdir+common
common/isa_pkg.sv
common/exec_pkg.sv
hw/issue_decode.sv
vector_lane/vector_lane.sv
hw/result_merge.sv
hw/vector_exec_top.sv
verification/vector_exec_sva.sv
verification/vector_exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vector execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module vector_exec_tb -o vector_exec_sim
./obj_dir/vector_exec_sim | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verification/vector_exec_tb.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module vector_exec_tb;

    import isa_pkg::*;
    import exec_pkg::*;

    typedef lane_word_t [`VEC_LANES-1:0] vec_t;

    // all tests together take well under a hundred cycles
    localparam int MAX_CYCLES = 2000;
    localparam int MSB = `VEC_WORD - 1;

    localparam lane_word_t ADD_A[4] = '{32'h7fffffff, 32'hffffffff, 32'h80000000, 32'h12345678};
    localparam lane_word_t ADD_B[4] = '{32'h00000001, 32'h00000001, 32'h80000000, 32'h0edcba98};
    localparam lane_word_t SUB_A[4] = '{32'h80000000, 32'h00000000, 32'h7fffffff, 32'h00000005};
    localparam lane_word_t SUB_B[4] = '{32'h00000001, 32'h00000001, 32'hffffffff, 32'h00000005};
    localparam lane_word_t SHAMT[4] = '{32'd0, 32'd31, 32'd32, 32'd40};
    // low 5 bits differ from the full amount
    localparam lane_word_t ROTAMT[4] = '{32'd33, 32'd63, 32'd39, 32'h10000024};

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    isa_opcode_e           opcode;
    isa_sub_e              sub_opcode;
    vec_t                  src1;
    vec_t                  src2;
    lane_word_t            imm;
    logic                  out_valid;
    vec_t                  result;
    logic [`VEC_LANES-1:0] overflow;

    int                    cycles = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    logic [31:0]           rng = 32'hafe7;
    vec_t                  exp_res_q[$];
    logic [`VEC_LANES-1:0] exp_ovf_q[$];
    int                    due_q[$];
    isa_opcode_e           ops[5] = '{TY_BASE, ADDI, ORI, XORI, MOVI};
    isa_sub_e              subs[8] = '{ADD, SUB, AND, OR, XOR, SRLI, SLLI, ROTRI};

    vector_exec_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles with results still pending", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < `VEC_LANES; i++)
            v[i] = xorshift();
        return v;
    endfunction

    function automatic vec_t from_table(input lane_word_t t[4]);
        vec_t v;
        for (int i = 0; i < `VEC_LANES; i++)
            v[i] = t[i % 4];
        return v;
    endfunction

    // one element, straight from the result rules
    function automatic void model(input isa_opcode_e opc, input isa_sub_e sub,
                                  input lane_word_t a, input lane_word_t b,
                                  input lane_word_t iv, output lane_word_t r, output logic ov);
        lane_word_t bb;
        int         amt;
        bb  = (opc == TY_BASE) ? b : iv;
        amt = bb % `VEC_WORD;
        r   = '0;
        ov  = 1'b0;
        if (opc == MOVI)
            r = iv;
        else if (opc == ADDI || (opc == TY_BASE && sub == ADD))
        begin
            r  = a + bb;
            ov = (a[MSB] == bb[MSB]) && (r[MSB] != a[MSB]);
        end
        else if (opc == TY_BASE && sub == SUB)
        begin
            r  = a - bb;
            ov = (a[MSB] != bb[MSB]) && (r[MSB] != a[MSB]);
        end
        else if (opc == ORI || (opc == TY_BASE && sub == OR))
            r = a | bb;
        else if (opc == XORI || (opc == TY_BASE && sub == XOR))
            r = a ^ bb;
        else if (opc == TY_BASE && sub == AND)
            r = a & bb;
        else if (opc == TY_BASE && sub == SRLI)
            r = (bb >= `VEC_WORD) ? '0 : a >> bb;
        else if (opc == TY_BASE && sub == SLLI)
            r = (bb >= `VEC_WORD) ? '0 : a << bb;
        else if (opc == TY_BASE && sub == ROTRI)
            r = (a >> amt) | (a << ((`VEC_WORD - amt) % `VEC_WORD));
    endfunction

    task automatic compare_result(input vec_t got, input vec_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("ERROR %0t: result %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_overflow(input logic [`VEC_LANES-1:0] got,
                                    input logic [`VEC_LANES-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("ERROR %0t: overflow %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("ERROR %0t: out_valid %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    // one instruction per call, expected values queued for the monitor
    task automatic issue(input isa_opcode_e opc, input isa_sub_e sub,
                         input vec_t a, input vec_t b, input lane_word_t iv);
        vec_t                  r;
        logic [`VEC_LANES-1:0] ov;
        lane_word_t            e;
        logic                  o;
        @(posedge clk);
        #1;
        in_valid   = 1'b1;
        opcode     = opc;
        sub_opcode = sub;
        src1       = a;
        src2       = b;
        imm        = iv;
        for (int i = 0; i < `VEC_LANES; i++)
        begin
            model(opc, sub, a[i], b[i], iv, e, o);
            r[i]  = e;
            ov[i] = o;
        end
        exp_res_q.push_back(r);
        exp_ovf_q.push_back(ov);
        due_q.push_back(cycles + 3);
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (due_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        $display("test %-12s done, %0d errors", name, errors - e0);
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (due_q.size() != 0 && due_q[0] == cycles)
            begin
                if (!out_valid)
                begin
                    $display("no out_valid three cycles after issue, time %0t", $time);
                    errors++;
                end
                else
                begin
                    compare_result(result, exp_res_q[0]);
                    compare_overflow(overflow, exp_ovf_q[0]);
                end
                void'(exp_res_q.pop_front());
                void'(exp_ovf_q.pop_front());
                void'(due_q.pop_front());
            end
            else if (out_valid)
            begin
                $display("out_valid raised with no instruction due, time %0t", $time);
                errors++;
            end
        end
    end

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        @(negedge clk);
        compare_valid(out_valid, 1'b0);
        compare_result(result, '0);
        compare_overflow(overflow, '0);
        repeat (5) @(posedge clk);
        report_test("reset", e0);
    endtask

    task automatic add_sub_test();
        int e0;
        e0 = errors;
        issue(TY_BASE, ADD, from_table(ADD_A), from_table(ADD_B), '0);
        issue(TY_BASE, SUB, from_table(SUB_A), from_table(SUB_B), '0);
        repeat (4)
        begin
            issue(TY_BASE, ADD, rand_vec(), rand_vec(), '0);
            issue(TY_BASE, SUB, rand_vec(), rand_vec(), '0);
        end
        drain();
        report_test("add_sub", e0);
    endtask

    task automatic logic_shift_test();
        vec_t a;
        int   e0;
        e0 = errors;
        a  = rand_vec();
        issue(TY_BASE, AND, a, rand_vec(), '0);
        issue(TY_BASE, OR, a, rand_vec(), '0);
        issue(TY_BASE, XOR, a, rand_vec(), '0);
        issue(TY_BASE, SRLI, a, from_table(SHAMT), '0);
        issue(TY_BASE, SLLI, a, from_table(SHAMT), '0);
        issue(TY_BASE, ROTRI, a, from_table(ROTAMT), '0);
        issue(TY_BASE, ROTRI, rand_vec(), from_table(SHAMT), '0);
        drain();
        report_test("logic_shift", e0);
    endtask

    task automatic immediate_test();
        int e0;
        e0 = errors;
        issue(ADDI, ADD, from_table(ADD_A), rand_vec(), 32'h1);
        issue(ADDI, ADD, rand_vec(), rand_vec(), 32'h7fffffff);
        issue(ORI, ADD, rand_vec(), rand_vec(), xorshift());
        issue(XORI, ADD, rand_vec(), rand_vec(), xorshift());
        issue(MOVI, ADD, rand_vec(), rand_vec(), xorshift());
        drain();
        report_test("immediate", e0);
    endtask

    task automatic unknown_code_test();
        int e0;
        e0 = errors;
        issue(isa_opcode_e'(6'h3f), ADD, rand_vec(), rand_vec(), xorshift());
        issue(TY_BASE, isa_sub_e'(5'h1f), rand_vec(), rand_vec(), xorshift());
        drain();
        report_test("unknown", e0);
    endtask

    task automatic back_to_back_test();
        int e0;
        int k;
        int s;
        e0 = errors;
        repeat (20)
        begin
            k = int'(xorshift() % 32'd5);
            s = int'(xorshift() % 32'd8);
            issue(ops[k], subs[s], rand_vec(), rand_vec(), xorshift());
        end
        drain();
        report_test("back_to_back", e0);
    endtask

    initial
    begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        opcode     = TY_BASE;
        sub_opcode = ADD;
        src1       = '0;
        src2       = '0;
        imm        = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_state_test();
        add_sub_test();
        logic_shift_test();
        immediate_test();
        unknown_code_test();
        back_to_back_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verification/vector_exec_sva.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module vector_exec_sva
(
    input logic                  clk,
    input logic                  reset,
    input logic                  in_valid,
    input isa_pkg::isa_opcode_e  opcode,
    input isa_pkg::isa_sub_e     sub_opcode,
    input logic                  out_valid,
    input logic [`VEC_LANES-1:0] overflow
);

    import isa_pkg::*;

    logic is_arith;

    // only add and subtract may flag overflow
    assign is_arith = (opcode == ADDI)
                   || (opcode == TY_BASE && (sub_opcode == ADD || sub_opcode == SUB));

    a_latency_fwd: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##3 out_valid)
        else $error("out_valid missing 3 cycles after in_valid");

    a_latency_back: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without in_valid 3 cycles earlier");

    a_reset_low: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid high while in reset");

    a_ovf_arith: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !$past(is_arith, 3)) |-> (overflow == '0))
        else $error("overflow set for a non-arithmetic operation");

endmodule

bind vector_exec_top vector_exec_sva u_sva
(
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .opcode     (opcode),
    .sub_opcode (sub_opcode),
    .out_valid  (out_valid),
    .overflow   (overflow)
);

//--- hw/vector_exec_top.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module vector_exec_top
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  isa_pkg::isa_opcode_e                   opcode,
    input  isa_pkg::isa_sub_e                      sub_opcode,
    input  exec_pkg::lane_word_t [`VEC_LANES-1:0]  src1,
    input  exec_pkg::lane_word_t [`VEC_LANES-1:0]  src2,
    input  exec_pkg::lane_word_t                   imm,
    output logic                                   out_valid,
    output exec_pkg::lane_word_t [`VEC_LANES-1:0]  result,
    output logic [`VEC_LANES-1:0]                  overflow
);

    import exec_pkg::*;

    logic                        lane_valid;
    alu_op_e                     lane_op;
    lane_word_t [`VEC_LANES-1:0] lane_a;
    lane_word_t [`VEC_LANES-1:0] lane_b;
    logic [`VEC_LANES-1:0]       res_valid;
    lane_word_t [`VEC_LANES-1:0] res;
    logic [`VEC_LANES-1:0]       ovf;

    issue_decode u_issue_decode
    (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .opcode     (opcode),
        .sub_opcode (sub_opcode),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .lane_valid (lane_valid),
        .lane_op    (lane_op),
        .lane_a     (lane_a),
        .lane_b     (lane_b)
    );

    for (genvar i = 0; i < `VEC_LANES; i++)
    begin : g_lane
        vector_lane u_lane
        (
            .clk       (clk),
            .reset     (reset),
            .valid     (lane_valid),
            .op        (lane_op),
            .a         (lane_a[i]),
            .b         (lane_b[i]),
            .res_valid (res_valid[i]),
            .res       (res[i]),
            .ovf       (ovf[i])
        );
    end

    result_merge u_result_merge
    (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res       (res),
        .ovf       (ovf),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow)
    );

endmodule

//--- hw/result_merge.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module result_merge
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [`VEC_LANES-1:0]                  res_valid,
    input  exec_pkg::lane_word_t [`VEC_LANES-1:0]  res,
    input  logic [`VEC_LANES-1:0]                  ovf,
    output logic                                   out_valid,
    output exec_pkg::lane_word_t [`VEC_LANES-1:0]  result,
    output logic [`VEC_LANES-1:0]                  overflow
);

    logic all_valid;

    // lanes always issue together
    assign all_valid = &res_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            result    <= '0;
            overflow  <= '0;
        end
        else
        begin
            out_valid <= all_valid;
            // hold last vector between results
            if (all_valid)
            begin
                result   <= res;
                overflow <= ovf;
            end
        end
    end

endmodule

//--- vector_lane/vector_lane.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module vector_lane
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  exec_pkg::alu_op_e    op,
    input  exec_pkg::lane_word_t a,
    input  exec_pkg::lane_word_t b,
    output logic                 res_valid,
    output exec_pkg::lane_word_t res,
    output logic                 ovf
);

    import exec_pkg::*;

    localparam int MSB  = `VEC_WORD - 1;
    localparam int SH_W = $clog2(`VEC_WORD);

    logic                   is_sub;
    lane_word_t             b_eff;
    logic [MSB-1:0]         sum_lo;
    logic                   sum_hi;
    logic                   c_in_msb;
    logic                   c_out_msb;
    logic [2*`VEC_WORD-1:0] rot_pair;
    lane_word_t             next_res;
    logic                   next_ovf;

    always_comb
    begin
        // subtract as a + ~b + 1, split at the msb for both carries
        is_sub = (op == OP_SUB);
        b_eff  = is_sub ? ~b : b;
        {c_in_msb, sum_lo} = {1'b0, a[MSB-1:0]}
                           + {1'b0, b_eff[MSB-1:0]}
                           + {{MSB{1'b0}}, is_sub};
        {c_out_msb, sum_hi} = {1'b0, a[MSB]} + {1'b0, b_eff[MSB]} + {1'b0, c_in_msb};

        // rotate uses only the low bits of b
        rot_pair = {a, a} >> b[SH_W-1:0];

        next_res = '0;
        next_ovf = 1'b0;
        case (op)
            OP_ADD, OP_SUB:
            begin
                next_res = {sum_hi, sum_lo};
                next_ovf = c_in_msb ^ c_out_msb;
            end
            OP_AND:  next_res = a & b;
            OP_OR:   next_res = a | b;
            OP_XOR:  next_res = a ^ b;
            // full-width amount, 32 and up shifts everything out
            OP_SRL:  next_res = a >> b;
            OP_SLL:  next_res = a << b;
            OP_ROR:  next_res = rot_pair[MSB:0];
            OP_MOV:  next_res = a;
            OP_NONE: next_res = '0;
            default: next_res = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            res_valid <= 1'b0;
        else
            res_valid <= valid;
    end

    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            res <= next_res;
            ovf <= next_ovf;
        end
    end

endmodule

//--- hw/issue_decode.sv
`timescale 1ns/1ps
`include "vector_exec_settings.svh"

module issue_decode
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  isa_pkg::isa_opcode_e                   opcode,
    input  isa_pkg::isa_sub_e                      sub_opcode,
    input  exec_pkg::lane_word_t [`VEC_LANES-1:0]  src1,
    input  exec_pkg::lane_word_t [`VEC_LANES-1:0]  src2,
    input  exec_pkg::lane_word_t                   imm,
    output logic                                   lane_valid,
    output exec_pkg::alu_op_e                      lane_op,
    output exec_pkg::lane_word_t [`VEC_LANES-1:0]  lane_a,
    output exec_pkg::lane_word_t [`VEC_LANES-1:0]  lane_b
);

    import isa_pkg::*;
    import exec_pkg::*;

    alu_op_e                     dec_op;
    lane_word_t [`VEC_LANES-1:0] dec_a;
    lane_word_t [`VEC_LANES-1:0] dec_b;
    lane_word_t [`VEC_LANES-1:0] imm_bcast;

    assign imm_bcast = {`VEC_LANES{imm}};

    // decode once for all lanes
    always_comb
    begin
        dec_op = OP_NONE;
        dec_a  = src1;
        dec_b  = src2;
        case (opcode)
            TY_BASE:
            begin
                case (sub_opcode)
                    ADD:     dec_op = OP_ADD;
                    SUB:     dec_op = OP_SUB;
                    AND:     dec_op = OP_AND;
                    OR:      dec_op = OP_OR;
                    XOR:     dec_op = OP_XOR;
                    SRLI:    dec_op = OP_SRL;
                    SLLI:    dec_op = OP_SLL;
                    ROTRI:   dec_op = OP_ROR;
                    default: dec_op = OP_NONE;
                endcase
            end
            ADDI:
            begin
                dec_op = OP_ADD;
                dec_b  = imm_bcast;
            end
            ORI:
            begin
                dec_op = OP_OR;
                dec_b  = imm_bcast;
            end
            XORI:
            begin
                dec_op = OP_XOR;
                dec_b  = imm_bcast;
            end
            MOVI:
            begin
                // lane passes operand a through
                dec_op = OP_MOV;
                dec_a  = imm_bcast;
                dec_b  = imm_bcast;
            end
            default: dec_op = OP_NONE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lane_valid <= 1'b0;
        else
            lane_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            lane_op <= dec_op;
            lane_a  <= dec_a;
            lane_b  <= dec_b;
        end
    end

endmodule

//--- common/exec_pkg.sv
`include "vector_exec_settings.svh"

package exec_pkg;

    // one lane element
    typedef logic [`VEC_WORD-1:0] lane_word_t;

    // decoded operation carried down the lanes
    typedef enum logic [3:0]
    {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SLL  = 4'd7,
        OP_ROR  = 4'd8,
        OP_MOV  = 4'd9
    } alu_op_e;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    // major opcode field
    typedef enum logic [5:0]
    {
        TY_BASE = 6'b100000,
        MOVI    = 6'b100010,
        ADDI    = 6'b101000,
        XORI    = 6'b101011,
        ORI     = 6'b101100
    } isa_opcode_e;

    // sub-opcode, only meaningful under TY_BASE
    typedef enum logic [4:0]
    {
        ADD   = 5'b00000,
        SUB   = 5'b00001,
        AND   = 5'b00010,
        XOR   = 5'b00011,
        OR    = 5'b00100,
        SLLI  = 5'b01000,
        SRLI  = 5'b01001,
        ROTRI = 5'b01011
    } isa_sub_e;

endpackage

//--- common/vector_exec_settings.svh
`ifndef VECTOR_EXEC_SETTINGS_SVH
`define VECTOR_EXEC_SETTINGS_SVH

// lanes issued together
// 2 and 8 also supported
`define VEC_LANES 4

// element width in bits
`define VEC_WORD 32

`endif
